// ==== hw/rv_isa_pkg.sv ====
package rv_isa_pkg;

    // RV32I major opcodes used by the back end
    typedef enum logic [6:0] {
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_ALU    = 7'b0110011,
        OP_ALUI   = 7'b0010011,
        OP_LUI    = 7'b0110111,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_SYSTEM = 7'b1110011
    } opcode_e;

    // funct3 of loads and stores
    typedef enum logic [2:0] {
        W_B  = 3'b000,
        W_H  = 3'b001,
        W_W  = 3'b010,
        W_BU = 3'b100,
        W_HU = 3'b101
    } ld_st_width_e;

    // Machine-mode CSR addresses
    localparam logic [11:0] CSR_MTVEC    = 12'h305;
    localparam logic [11:0] CSR_MSCRATCH = 12'h340;
    localparam logic [11:0] CSR_MEPC     = 12'h341;

    // mtvec base is word aligned, mode bits stay zero
    localparam logic [31:0] MTVEC_WMASK = 32'hffff_fffc;

endpackage

// ==== hw/pipe_pkg.sv ====
package pipe_pkg;

    import rv_isa_pkg::*;

    localparam int XLEN = 32;

    // Word index comes from address bits 7..2
    localparam int DMEM_WORDS = 64;

    // Execute results handed to the memory stage
    typedef struct packed {
        logic [XLEN-1:0] pc4;
        // Store data or new CSR value
        logic [XLEN-1:0] b;
        // ALU result or address
        logic [XLEN-1:0] c;
        logic [2:0]      funct3;
        logic [4:0]      rd;
        logic [11:0]     csr_addr;
        opcode_e         opcode;
        logic            wr_reg_n;
        logic            wr_csr_n;
        logic            flush;
    } ex_mem_t;

    // Registered writeback
    typedef struct packed {
        logic            wr_en;
        logic [4:0]      rd;
        logic [XLEN-1:0] data;
    } mem_wb_t;

endpackage

// ==== hw/ex_mem_regs.sv ====
`timescale 1ns/1ps

module ex_mem_regs
    import pipe_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  logic    interlock,
    input  ex_mem_t ex_in,
    output ex_mem_t ex_mem
);

    // Write enables come out of reset inactive so nothing is committed
    // before the first real instruction arrives
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_mem          <= '0;
            ex_mem.wr_reg_n <= 1'b1;
            ex_mem.wr_csr_n <= 1'b1;
            ex_mem.flush    <= 1'b0;
        end else if (!interlock) begin
            ex_mem <= ex_in;
        end
    end

endmodule

// ==== hw/csr_file.sv ====
`timescale 1ns/1ps

module csr_file
    import rv_isa_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic [11:0] csr_addr,
    input  logic        csr_we,
    input  logic [31:0] csr_wdata,
    output logic [31:0] csr_rdata
);

    logic [31:0] mtvec;
    logic [31:0] mscratch;
    logic [31:0] mepc;

    // Unknown addresses read as zero
    always_comb begin
        case (csr_addr)
            CSR_MTVEC: begin
                csr_rdata = mtvec;
            end
            CSR_MSCRATCH: begin
                csr_rdata = mscratch;
            end
            CSR_MEPC: begin
                csr_rdata = mepc;
            end
            default: begin
                csr_rdata = '0;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mtvec    <= '0;
            mscratch <= '0;
            mepc     <= '0;
        end else if (csr_we) begin
            case (csr_addr)
                CSR_MTVEC: begin
                    mtvec <= csr_wdata & MTVEC_WMASK;
                end
                CSR_MSCRATCH: begin
                    mscratch <= csr_wdata;
                end
                CSR_MEPC: begin
                    mepc <= csr_wdata;
                end
                default: begin
                    // writes to unimplemented CSRs are dropped
                end
            endcase
        end
    end

endmodule

// ==== hw/mem_stage.sv ====
`timescale 1ns/1ps

module mem_stage
    import rv_isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        interlock,
    input  ex_mem_t     ex_mem,
    output logic [11:0] csr_addr,
    output logic        csr_we,
    output logic [31:0] csr_wdata,
    input  logic [31:0] csr_rdata,
    output mem_wb_t     wb
);

    logic [XLEN-1:0]                 dmem [DMEM_WORDS];
    logic [$clog2(DMEM_WORDS)-1:0]   word_idx;
    logic [1:0]                      byte_off;
    ld_st_width_e                    width;
    logic                            commit;
    logic                            is_load;
    logic                            is_store;
    logic [3:0]                      st_be;
    logic [XLEN-1:0]                 st_data;
    logic [XLEN-1:0]                 ld_word;
    logic [7:0]                      ld_byte;
    logic [15:0]                     ld_half;
    logic [XLEN-1:0]                 ld_data;
    logic [XLEN-1:0]                 result;

    // Address bits above the memory size wrap
    assign word_idx = ex_mem.c[$clog2(DMEM_WORDS)+1:2];
    assign byte_off = ex_mem.c[1:0];
    assign width    = ld_st_width_e'(ex_mem.funct3);

    assign commit   = !ex_mem.flush && !interlock;
    assign is_load  = (ex_mem.opcode == OP_LOAD);
    assign is_store = (ex_mem.opcode == OP_STORE);

    // CSR access is read-then-write within the commit cycle
    assign csr_addr  = ex_mem.csr_addr;
    assign csr_wdata = ex_mem.b;
    assign csr_we    = commit && !ex_mem.wr_csr_n;

    // Store data replicated so any lane can pick it up
    always_comb begin
        case (width)
            W_B, W_BU: begin
                st_be   = 4'b0001 << byte_off;
                st_data = {4{ex_mem.b[7:0]}};
            end
            W_H, W_HU: begin
                st_be   = 4'b0011 << {byte_off[1], 1'b0};
                st_data = {2{ex_mem.b[15:0]}};
            end
            default: begin
                st_be   = 4'b1111;
                st_data = ex_mem.b;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (commit && is_store) begin
            for (int i = 0; i < 4; i++) begin
                if (st_be[i]) begin
                    dmem[word_idx][8*i +: 8] <= st_data[8*i +: 8];
                end
            end
        end
    end

    // Load extraction
    assign ld_word = dmem[word_idx];
    assign ld_byte = ld_word[8*byte_off +: 8];
    assign ld_half = byte_off[1] ? ld_word[31:16] : ld_word[15:0];

    always_comb begin
        case (width)
            W_B:     ld_data = {{24{ld_byte[7]}}, ld_byte};
            W_BU:    ld_data = {24'd0, ld_byte};
            W_H:     ld_data = {{16{ld_half[15]}}, ld_half};
            W_HU:    ld_data = {16'd0, ld_half};
            default: ld_data = ld_word;
        endcase
    end

    always_comb begin
        if (is_load) begin
            result = ld_data;
        end else begin
            case (ex_mem.opcode)
                OP_JAL, OP_JALR: result = ex_mem.pc4;
                // Old CSR value
                OP_SYSTEM:       result = csr_rdata;
                default:         result = ex_mem.c;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb <= '0;
        end else begin
            wb.wr_en <= commit && !ex_mem.wr_reg_n;
            wb.rd    <= ex_mem.rd;
            wb.data  <= result;
        end
    end

endmodule

// ==== hw/rv_backend_top.sv ====
`timescale 1ns/1ps

module rv_backend_top
    import pipe_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  logic    interlock,
    input  ex_mem_t ex_in,
    output mem_wb_t wb
);

    ex_mem_t     ex_mem;
    logic [11:0] csr_addr;
    logic        csr_we;
    logic [31:0] csr_wdata;
    logic [31:0] csr_rdata;

    ex_mem_regs i_ex_mem_regs (
        .clk       (clk),
        .rst_n     (rst_n),
        .interlock (interlock),
        .ex_in     (ex_in),
        .ex_mem    (ex_mem)
    );

    mem_stage i_mem_stage (
        .clk       (clk),
        .rst_n     (rst_n),
        .interlock (interlock),
        .ex_mem    (ex_mem),
        .csr_addr  (csr_addr),
        .csr_we    (csr_we),
        .csr_wdata (csr_wdata),
        .csr_rdata (csr_rdata),
        .wb        (wb)
    );

    csr_file i_csr_file (
        .clk       (clk),
        .rst_n     (rst_n),
        .csr_addr  (csr_addr),
        .csr_we    (csr_we),
        .csr_wdata (csr_wdata),
        .csr_rdata (csr_rdata)
    );

endmodule

// ==== tests/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Reset held over the first two rising edges
    initial begin
        rst_n = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
    end

endmodule

// ==== tests/tb_rv_backend.sv ====
`timescale 1ns/1ps

module tb_rv_backend
    import rv_isa_pkg::*;
    import pipe_pkg::*;
();

    localparam int N_ALU     = 30;
    localparam int N_INIT    = DMEM_WORDS;
    localparam int N_LDST    = 3 * 6;
    localparam int N_JUMP    = 2;
    localparam int N_CSR     = 4 * 2;
    localparam int N_FLUSH   = 4;
    localparam int N_RAND    = 400;
    localparam int N_DRAIN   = 3;
    localparam int NUM_INSTR = N_ALU + N_INIT + N_LDST + N_JUMP + N_CSR + N_FLUSH
                               + N_RAND + N_DRAIN;
    localparam logic [11:0] CSR_UNKNOWN = 12'h7c0;

    logic        clk;
    logic        rst_n;
    logic        interlock;
    ex_mem_t     ex_in;
    mem_wb_t     wb;

    logic [31:0] rng_state = 32'hcaa6c6a3;

    // Reference model state
    ex_mem_t     m_ex;
    mem_wb_t     exp_wb;
    logic [31:0] model_mem [DMEM_WORDS];
    logic [31:0] m_mtvec;
    logic [31:0] m_mscratch;
    logic [31:0] m_mepc;

    tb_clock_gen i_clock_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    rv_backend_top i_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .interlock (interlock),
        .ex_in     (ex_in),
        .wb        (wb)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Fail %s: got %h, expected %h", name, actual, expected);
            $display("Verification failed");
            $fatal(1);
        end
    endtask

    function automatic logic [31:0] load_value(input logic [31:0] word,
                                               input logic [1:0] off, input logic [2:0] f3);
        logic [31:0] by;
        logic [31:0] hw;
        by = word >> (8 * off);
        hw = word >> (16 * off[1]);
        case (f3)
            W_B:     return {{24{by[7]}}, by[7:0]};
            W_BU:    return {24'd0, by[7:0]};
            W_H:     return {{16{hw[15]}}, hw[15:0]};
            W_HU:    return {16'd0, hw[15:0]};
            default: return word;
        endcase
    endfunction

    function automatic logic [31:0] store_merge(input logic [31:0] word, input logic [1:0] off,
                                                input logic [2:0] f3, input logic [31:0] b);
        logic [31:0] res;
        res = word;
        case (f3)
            W_B, W_BU: res[8*off +: 8] = b[7:0];
            W_H, W_HU: res[16*off[1] +: 16] = b[15:0];
            default:   res = b;
        endcase
        return res;
    endfunction

    function automatic logic [31:0] csr_read(input logic [11:0] addr);
        case (addr)
            CSR_MTVEC:    return m_mtvec;
            CSR_MSCRATCH: return m_mscratch;
            CSR_MEPC:     return m_mepc;
            default:      return 32'd0;
        endcase
    endfunction

    task automatic csr_write(input logic [11:0] addr, input logic [31:0] val);
        case (addr)
            CSR_MTVEC:    m_mtvec = val & MTVEC_WMASK;
            CSR_MSCRATCH: m_mscratch = val;
            CSR_MEPC:     m_mepc = val;
            default:      ;
        endcase
    endtask

    function automatic logic [2:0] pick_width(input int sel);
        case (sel)
            0:       return W_B;
            1:       return W_H;
            2:       return W_W;
            3:       return W_BU;
            default: return W_HU;
        endcase
    endfunction

    function automatic logic [11:0] pick_csr(input logic [1:0] sel);
        case (sel)
            2'd0:    return CSR_MTVEC;
            2'd1:    return CSR_MSCRATCH;
            2'd2:    return CSR_MEPC;
            default: return CSR_UNKNOWN;
        endcase
    endfunction

    // Random payload, register write on, no CSR write, no flush
    function automatic ex_mem_t base_instr(input opcode_e op);
        ex_mem_t     t;
        logic [31:0] r;
        r          = next_rand();
        t.pc4      = next_rand();
        t.b        = next_rand();
        t.c        = next_rand();
        t.funct3   = r[7:5];
        t.rd       = r[4:0];
        t.csr_addr = r[19:8];
        t.opcode   = op;
        t.wr_reg_n = 1'b0;
        t.wr_csr_n = 1'b1;
        t.flush    = 1'b0;
        return t;
    endfunction

    function automatic ex_mem_t random_instr();
        ex_mem_t     t;
        logic [31:0] r;
        r = next_rand();
        case (r[2:0])
            3'd0: begin
                t        = base_instr(OP_LOAD);
                t.funct3 = pick_width(int'(r[15:8]) % 5);
                t.c      = {24'd0, r[31:24]};
            end
            3'd1: begin
                t          = base_instr(OP_STORE);
                t.funct3   = pick_width(int'(r[15:8]) % 3);
                t.c        = {24'd0, r[31:24]};
                t.wr_reg_n = 1'b1;
            end
            3'd2: t = base_instr(OP_ALU);
            3'd3: t = base_instr(OP_ALUI);
            3'd4: t = base_instr(OP_LUI);
            3'd5: t = base_instr(r[3] ? OP_JAL : OP_JALR);
            default: begin
                t          = base_instr(OP_SYSTEM);
                t.csr_addr = pick_csr(r[9:8]);
                t.wr_csr_n = r[10] & r[11];
            end
        endcase
        if (r[18:16] == 3'd0) begin
            t.wr_reg_n = 1'b1;
        end
        t.flush = (r[21:19] == 3'd0);
        return t;
    endfunction

    // One clock of the commit rule, applied to the model
    task automatic model_cycle(input logic stall, input ex_mem_t nxt);
        logic        commit;
        logic [5:0]  idx;
        logic [31:0] res;
        commit = !m_ex.flush && !stall;
        idx    = m_ex.c[7:2];
        case (m_ex.opcode)
            OP_LOAD:         res = load_value(model_mem[idx], m_ex.c[1:0], m_ex.funct3);
            OP_JAL, OP_JALR: res = m_ex.pc4;
            OP_SYSTEM:       res = csr_read(m_ex.csr_addr);
            default:         res = m_ex.c;
        endcase
        exp_wb.wr_en = commit && !m_ex.wr_reg_n;
        exp_wb.rd    = m_ex.rd;
        exp_wb.data  = res;
        if (commit && m_ex.opcode == OP_STORE) begin
            model_mem[idx] = store_merge(model_mem[idx], m_ex.c[1:0], m_ex.funct3, m_ex.b);
        end
        if (commit && !m_ex.wr_csr_n) begin
            csr_write(m_ex.csr_addr, m_ex.b);
        end
        if (!stall) begin
            m_ex = nxt;
        end
    endtask

    task automatic check_wb();
        check_value("wb.wr_en", 32'(wb.wr_en), 32'(exp_wb.wr_en));
        if (exp_wb.wr_en) begin
            check_value("wb.rd", 32'(wb.rd), 32'(exp_wb.rd));
            check_value("wb.data", wb.data, exp_wb.data);
        end
    endtask

    task automatic step(input logic stall, input ex_mem_t instr);
        check_wb();
        interlock = stall;
        ex_in     = instr;
        model_cycle(stall, instr);
        @(posedge clk);
        #1;
    endtask

    initial begin
        #((NUM_INSTR + 20) * 10);
        $display("Timeout: the tests did not finish within %0d cycles", NUM_INSTR + 20);
        $display("Verification failed");
        $fatal(1);
    end

    initial begin
        ex_mem_t     t;
        logic [31:0] r;
        logic [7:0]  addr;
        interlock      = 1'b0;
        ex_in          = '0;
        ex_in.opcode   = OP_ALU;
        ex_in.wr_reg_n = 1'b1;
        ex_in.wr_csr_n = 1'b1;
        m_ex           = '0;
        m_ex.wr_reg_n  = 1'b1;
        m_ex.wr_csr_n  = 1'b1;
        exp_wb         = '0;
        m_mtvec        = '0;
        m_mscratch     = '0;
        m_mepc         = '0;

        @(negedge clk);
        check_value("wb.wr_en", 32'(wb.wr_en), 32'd0);
        wait (rst_n);

        for (int i = 0; i < N_ALU; i++) begin
            r = next_rand();
            case (r[1:0])
                2'd0:    t = base_instr(OP_ALU);
                2'd1:    t = base_instr(OP_ALUI);
                default: t = base_instr(OP_LUI);
            endcase
            t.wr_reg_n = (r[4:2] == 3'd0);
            step(1'b0, t);
        end

        // Known contents in every word before any load
        for (int i = 0; i < N_INIT; i++) begin
            t          = base_instr(OP_STORE);
            t.funct3   = W_W;
            t.c        = {24'd0, 6'(i), 2'b00};
            t.wr_reg_n = 1'b1;
            step(1'b0, t);
        end

        // Each store width, then loads of every width straight after
        for (int s = 0; s < 3; s++) begin
            r          = next_rand();
            addr       = r[7:0];
            t          = base_instr(OP_STORE);
            t.funct3   = pick_width(s);
            t.c        = {24'd0, addr};
            t.wr_reg_n = 1'b1;
            step(1'b0, t);
            for (int l = 0; l < 5; l++) begin
                r        = next_rand();
                t        = base_instr(OP_LOAD);
                t.funct3 = pick_width(l);
                t.c      = {24'd0, addr[7:2], r[1:0]};
                step(1'b0, t);
            end
        end

        step(1'b0, base_instr(OP_JAL));
        step(1'b0, base_instr(OP_JALR));

        // Write returns the old value, the read after it shows the new one
        for (int k = 0; k < 4; k++) begin
            t          = base_instr(OP_SYSTEM);
            t.csr_addr = pick_csr(2'(k));
            t.b        = t.b | 32'h3;
            t.wr_csr_n = 1'b0;
            step(1'b0, t);
            t.wr_csr_n = 1'b1;
            t.b        = next_rand();
            step(1'b0, t);
        end

        // Squashed store and CSR write
        r          = next_rand();
        addr       = r[7:0];
        t          = base_instr(OP_STORE);
        t.funct3   = W_W;
        t.c        = {24'd0, addr};
        t.flush    = 1'b1;
        step(1'b0, t);
        t          = base_instr(OP_LOAD);
        t.funct3   = W_W;
        t.c        = {24'd0, addr};
        step(1'b0, t);
        t          = base_instr(OP_SYSTEM);
        t.csr_addr = CSR_MSCRATCH;
        t.wr_csr_n = 1'b0;
        t.flush    = 1'b1;
        step(1'b0, t);
        t.wr_csr_n = 1'b1;
        t.flush    = 1'b0;
        step(1'b0, t);

        // Random traffic with ex_in held while interlock is up
        for (int i = 0; i < N_RAND; i++) begin
            r = next_rand();
            if (r[2:0] < 3'd2) begin
                step(1'b1, ex_in);
            end else begin
                step(1'b0, random_instr());
            end
        end

        for (int i = 0; i < N_DRAIN; i++) begin
            t          = base_instr(OP_ALU);
            t.wr_reg_n = 1'b1;
            step(1'b0, t);
        end

        $display("Verification passed");
        $finish;
    end

endmodule

// ==== sources.f ====
hw/rv_isa_pkg.sv
hw/pipe_pkg.sv
hw/ex_mem_regs.sv
hw/csr_file.sv
hw/mem_stage.sv
hw/rv_backend_top.sv
tests/tb_clock_gen.sv
tests/tb_rv_backend.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --timescale 1ns/1ps -j 0 \
        --top-module tb_rv_backend -f sources.f; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_rv_backend 2>&1)
status=$?
echo "$out"

if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "Verification passed"; then
    exit 0
fi

echo "Pass message not found in simulation output"
exit 1
